// ==== src/dcache_pkg.sv ====
package dcache_pkg;

	// Operation codes on both the master and the slave bus.
	// The code 2'b11 belongs to the read-write swap, which this cache
	// does not implement and treats as no operation.
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10
	} pi1_op_e;

	// States of the slave-side sequencer.
	// SC_WRITE drains the write buffer, SC_READ issues a miss read and
	// waits for its data, SC_DONE hands the word back to the master side.
	typedef enum logic [1:0] {
		SC_IDLE,
		SC_WRITE,
		SC_READ,
		SC_DONE
	} sctrl_state_e;

	// Bits covered by one byte select line.
	localparam int BYTE_W = 8;

endpackage

// ==== src/dcache_decode.sv ====
`timescale 1ns/10ps

module dcache_decode import dcache_pkg::*; #(
	parameter int ARCH_W = 32,
	parameter int SET_COUNT = 16,
	localparam int SEL_W = ARCH_W / BYTE_W,
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W),
	localparam int IDX_W = $clog2(SET_COUNT),
	localparam int TAG_W = ADDR_W - IDX_W
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              cenable_i,

	input  pi1_op_e           m_op_i,
	input  logic [ADDR_W-1:0] m_addr_i,
	input  logic [ARCH_W-1:0] m_data_i,
	input  logic [SEL_W-1:0]  m_sel_i,

	input  logic              sweeping_i,
	input  logic              buf_full_i,
	input  logic [TAG_W-1:0]  rd_tag_i,
	input  logic [ARCH_W-1:0] rd_data_i,
	input  logic [SEL_W-1:0]  rd_valid_i,
	input  logic              fill_i,
	input  logic [ARCH_W-1:0] fill_data_i,

	output logic [ARCH_W-1:0] m_data_o,
	output logic              m_rdy_o,
	output logic [IDX_W-1:0]  look_addr_o,
	output logic              wr_en_o,
	output logic [ADDR_W-1:0] wr_addr_o,
	output logic [ARCH_W-1:0] wr_data_o,
	output logic [SEL_W-1:0]  wr_sel_o,
	output logic              wr_fill_o,
	output logic              push_o,
	output logic              miss_rqst_o,
	output logic [ADDR_W-1:0] miss_addr_o
);

	// Request accepted at the previous edge.
	pi1_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [ARCH_W-1:0] data_q;
	logic [SEL_W-1:0]  sel_q;
	logic              en_q;

	// High while a read waits for its word from the slave.
	logic              wait_q;

	logic              hit;
	logic              rd_miss;

	// A hit needs the tag to match and every requested byte to be present.
	// With the cache disabled the read goes to the slave regardless.
	assign hit = en_q && (rd_tag_i == addr_q[ADDR_W-1:IDX_W]) &&
		((sel_q & ~rd_valid_i) == '0);
	assign rd_miss = (op_q == PI1_RDOP) && !hit;

	// In the fill cycle the master sees ready again and takes the slave word.
	assign m_rdy_o = !sweeping_i && !buf_full_i && !rd_miss && !(wait_q && !fill_i);
	assign m_data_o = fill_i ? fill_data_i : rd_data_i;

	// While stalled the held set is looked up again, so the store output
	// keeps tracking the pending request.
	assign look_addr_o = m_rdy_o ? m_addr_i[IDX_W-1:0] : addr_q[IDX_W-1:0];

	assign push_o = m_rdy_o && (m_op_i == PI1_WROP);

	assign miss_rqst_o = rd_miss || wait_q;
	assign miss_addr_o = addr_q;

	// Cache updates come from the held write or from the returning fill.
	assign wr_en_o = !sweeping_i && en_q && ((op_q == PI1_WROP) || fill_i);
	assign wr_addr_o = addr_q;
	assign wr_data_o = fill_i ? fill_data_i : data_q;
	assign wr_sel_o = sel_q;
	assign wr_fill_o = fill_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			op_q <= PI1_NOOP;
			wait_q <= 1'b0;
		end else begin
			// The unused swap code is taken as a no-op.
			if (m_rdy_o && (m_op_i == PI1_WROP || m_op_i == PI1_RDOP)) begin
				op_q <= m_op_i;
			end else begin
				op_q <= PI1_NOOP;
			end
			if (fill_i) begin
				wait_q <= 1'b0;
			end else if (rd_miss) begin
				wait_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (m_rdy_o) begin
			addr_q <= m_addr_i;
			data_q <= m_data_i;
			sel_q <= m_sel_i;
			en_q <= cenable_i;
		end
	end

	// A fill word is only expected while a read waits for it.
	assert property (@(posedge clk_i) disable iff (rst_i) fill_i |-> wait_q)
		else $error("fill arrived with no read waiting");

endmodule

// ==== src/dcache_store.sv ====
`timescale 1ns/10ps

module dcache_store import dcache_pkg::*; #(
	parameter int ARCH_W = 32,
	parameter int SET_COUNT = 16,
	localparam int SEL_W = ARCH_W / BYTE_W,
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W),
	localparam int IDX_W = $clog2(SET_COUNT),
	localparam int TAG_W = ADDR_W - IDX_W
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              crst_i,

	input  logic [IDX_W-1:0]  look_addr_i,

	input  logic              wr_en_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  logic [ARCH_W-1:0] wr_data_i,
	input  logic [SEL_W-1:0]  wr_sel_i,
	input  logic              wr_fill_i,

	output logic [TAG_W-1:0]  rd_tag_o,
	output logic [ARCH_W-1:0] rd_data_o,
	output logic [SEL_W-1:0]  rd_valid_o,
	output logic              sweeping_o
);

	logic [TAG_W-1:0]  tag_mem   [SET_COUNT];
	logic [ARCH_W-1:0] data_mem  [SET_COUNT];
	logic [SEL_W-1:0]  valid_mem [SET_COUNT];

	logic              sweep_q;
	logic [IDX_W-1:0]  sweep_idx;

	logic [IDX_W-1:0]  w_idx;
	logic [TAG_W-1:0]  w_tag;
	logic              w_match;
	logic [SEL_W-1:0]  w_sel;
	logic [SEL_W-1:0]  new_valid;
	logic [ARCH_W-1:0] new_data;

	assign w_idx = wr_addr_i[IDX_W-1:0];
	assign w_tag = wr_addr_i[ADDR_W-1:IDX_W];
	assign w_match = (tag_mem[w_idx] == w_tag);

	// A fill brings the whole word in.
	assign w_sel = wr_fill_i ? '1 : wr_sel_i;

	// On a tag match the new bytes join those already present.
	// Otherwise the set is taken over and only the written bytes count.
	assign new_valid = w_sel | (w_match ? valid_mem[w_idx] : '0);

	always_comb begin
		new_data = data_mem[w_idx];
		for (int b = 0; b < SEL_W; b++) begin
			if (w_sel[b]) begin
				new_data[b*BYTE_W +: BYTE_W] = wr_data_i[b*BYTE_W +: BYTE_W];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			tag_mem[w_idx] <= w_tag;
			data_mem[w_idx] <= new_data;
		end
	end

	always_ff @(posedge clk_i) begin
		if (sweep_q) begin
			valid_mem[sweep_idx] <= '0;
		end else if (wr_en_i) begin
			valid_mem[w_idx] <= new_valid;
		end
	end

	// Lookup is write-first, so a read right behind an update of the
	// same set already sees the merged word.
	always_ff @(posedge clk_i) begin
		if (wr_en_i && (w_idx == look_addr_i)) begin
			rd_tag_o <= w_tag;
			rd_data_o <= new_data;
			rd_valid_o <= new_valid;
		end else begin
			rd_tag_o <= tag_mem[look_addr_i];
			rd_data_o <= data_mem[look_addr_i];
			rd_valid_o <= valid_mem[look_addr_i];
		end
	end

	// The sweep walks from the last set down to set zero.
	always_ff @(posedge clk_i) begin
		if (rst_i || crst_i) begin
			sweep_q <= 1'b1;
			sweep_idx <= IDX_W'(SET_COUNT - 1);
		end else if (sweep_q) begin
			if (sweep_idx == '0) begin
				sweep_q <= 1'b0;
			end else begin
				sweep_idx <= sweep_idx - 1'b1;
			end
		end
	end

	assign sweeping_o = sweep_q;

	// The master side must hold off cache updates for the whole sweep.
	assert property (@(posedge clk_i) disable iff (rst_i) !(wr_en_i && sweeping_o))
		else $error("cache update during valid-bit sweep");

endmodule

// ==== src/dcache_wbuf.sv ====
`timescale 1ns/10ps

module dcache_wbuf import dcache_pkg::*; #(
	parameter int ARCH_W = 32,
	parameter int BUF_DEPTH = 4,
	localparam int SEL_W = ARCH_W / BYTE_W,
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W)
) (
	input  logic              clk_i,
	input  logic              rst_i,

	input  logic              push_i,
	input  logic [ADDR_W-1:0] push_addr_i,
	input  logic [ARCH_W-1:0] push_data_i,
	input  logic [SEL_W-1:0]  push_sel_i,
	input  logic              pop_i,

	output logic [ADDR_W-1:0] head_addr_o,
	output logic [ARCH_W-1:0] head_data_o,
	output logic [SEL_W-1:0]  head_sel_o,
	output logic              empty_o,
	output logic              full_o
);

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	logic [ADDR_W-1:0] addr_mem [BUF_DEPTH];
	logic [ARCH_W-1:0] data_mem [BUF_DEPTH];
	logic [SEL_W-1:0]  sel_mem  [BUF_DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// Pointers wrap explicitly so the depth need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop_i) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push_i && !pop_i) begin
				count <= count + 1'b1;
			end else if (pop_i && !push_i) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			addr_mem[wr_ptr] <= push_addr_i;
			data_mem[wr_ptr] <= push_data_i;
			sel_mem[wr_ptr] <= push_sel_i;
		end
	end

	assign head_addr_o = addr_mem[rd_ptr];
	assign head_data_o = data_mem[rd_ptr];
	assign head_sel_o = sel_mem[rd_ptr];
	assign empty_o = (count == '0);
	assign full_o = (count == CNT_W'(BUF_DEPTH));

	assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
		else $error("write buffer popped while empty");

	assert property (@(posedge clk_i) disable iff (rst_i) (push_i && full_o) |-> pop_i)
		else $error("write buffer pushed while full");

endmodule

// ==== src/dcache_slave_ctrl.sv ====
`timescale 1ns/10ps

module dcache_slave_ctrl import dcache_pkg::*; #(
	parameter int ARCH_W = 32,
	localparam int SEL_W = ARCH_W / BYTE_W,
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W)
) (
	input  logic              clk_i,
	input  logic              rst_i,

	input  logic [ADDR_W-1:0] head_addr_i,
	input  logic [ARCH_W-1:0] head_data_i,
	input  logic [SEL_W-1:0]  head_sel_i,
	input  logic              empty_i,

	input  logic              miss_rqst_i,
	input  logic [ADDR_W-1:0] miss_addr_i,

	input  logic [ARCH_W-1:0] s_data_i,
	input  logic              s_rdy_i,

	output logic              pop_o,
	output logic              fill_o,
	output logic [ARCH_W-1:0] fill_data_o,

	output pi1_op_e           s_op_o,
	output logic [ADDR_W-1:0] s_addr_o,
	output logic [ARCH_W-1:0] s_data_o,
	output logic [SEL_W-1:0]  s_sel_o
);

	sctrl_state_e      state_q;
	sctrl_state_e      state_d;

	// Set once the slave has taken the read, cleared when its data arrives.
	logic              issued_q;
	logic [ARCH_W-1:0] fill_q;

	// Pending writes always go out first, so a miss read never overtakes them.
	always_comb begin
		state_d = state_q;
		case (state_q)
			SC_IDLE: begin
				if (!empty_i) begin
					state_d = SC_WRITE;
				end else if (miss_rqst_i) begin
					state_d = SC_READ;
				end
			end
			SC_WRITE: begin
				if (empty_i) begin
					state_d = miss_rqst_i ? SC_READ : SC_IDLE;
				end
			end
			SC_READ: begin
				if (issued_q && s_rdy_i) begin
					state_d = SC_DONE;
				end
			end
			default: state_d = SC_IDLE;
		endcase
	end

	always_comb begin
		s_op_o = PI1_NOOP;
		if (state_q == SC_WRITE && !empty_i) begin
			s_op_o = PI1_WROP;
		end else if (state_q == SC_READ && !issued_q) begin
			s_op_o = PI1_RDOP;
		end
	end

	// Miss reads always fetch the full word.
	assign s_addr_o = (state_q == SC_READ) ? miss_addr_i : head_addr_i;
	assign s_data_o = head_data_i;
	assign s_sel_o = (state_q == SC_READ) ? '1 : head_sel_i;

	assign pop_o = (state_q == SC_WRITE) && !empty_i && s_rdy_i;
	assign fill_o = (state_q == SC_DONE);
	assign fill_data_o = fill_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= SC_IDLE;
			issued_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == SC_READ && s_rdy_i) begin
				issued_q <= !issued_q;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == SC_READ && issued_q && s_rdy_i) begin
			fill_q <= s_data_i;
		end
	end

	// The master side keeps its request up until the word has returned.
	assert property (@(posedge clk_i) disable iff (rst_i) (state_q == SC_READ) |-> miss_rqst_i)
		else $error("miss request dropped during the slave read");

	// No new write may enter the buffer while a miss read is in flight.
	assert property (@(posedge clk_i) disable iff (rst_i) (state_q == SC_READ) |-> empty_i)
		else $error("write pending during miss read");

endmodule

// ==== src/pi1_dcache.sv ====
`timescale 1ns/10ps

module pi1_dcache import dcache_pkg::*; #(
	parameter int ARCH_W = 32,
	parameter int SET_COUNT = 16,
	parameter int BUF_DEPTH = 4,
	localparam int SEL_W = ARCH_W / BYTE_W,
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W)
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              crst_i,
	input  logic              cenable_i,

	input  pi1_op_e           m_op_i,
	input  logic [ADDR_W-1:0] m_addr_i,
	input  logic [ARCH_W-1:0] m_data_i,
	input  logic [SEL_W-1:0]  m_sel_i,
	output logic [ARCH_W-1:0] m_data_o,
	output logic              m_rdy_o,

	output pi1_op_e           s_op_o,
	output logic [ADDR_W-1:0] s_addr_o,
	output logic [ARCH_W-1:0] s_data_o,
	output logic [SEL_W-1:0]  s_sel_o,
	input  logic [ARCH_W-1:0] s_data_i,
	input  logic              s_rdy_i
);

	localparam int IDX_W = $clog2(SET_COUNT);
	localparam int TAG_W = ADDR_W - IDX_W;

	// Store lookup and update.
	logic [IDX_W-1:0]  look_addr;
	logic [TAG_W-1:0]  rd_tag;
	logic [ARCH_W-1:0] rd_data;
	logic [SEL_W-1:0]  rd_valid;
	logic              sweeping;
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [ARCH_W-1:0] wr_data;
	logic [SEL_W-1:0]  wr_sel;
	logic              wr_fill;

	// Write buffer.
	logic              push;
	logic              pop;
	logic              buf_empty;
	logic              buf_full;
	logic [ADDR_W-1:0] head_addr;
	logic [ARCH_W-1:0] head_data;
	logic [SEL_W-1:0]  head_sel;

	// Miss handling between the master side and the slave sequencer.
	logic              miss_rqst;
	logic [ADDR_W-1:0] miss_addr;
	logic              fill;
	logic [ARCH_W-1:0] fill_data;

	dcache_decode #(
		.ARCH_W   (ARCH_W),
		.SET_COUNT(SET_COUNT)
	) decode0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cenable_i  (cenable_i),
		.m_op_i     (m_op_i),
		.m_addr_i   (m_addr_i),
		.m_data_i   (m_data_i),
		.m_sel_i    (m_sel_i),
		.sweeping_i (sweeping),
		.buf_full_i (buf_full),
		.rd_tag_i   (rd_tag),
		.rd_data_i  (rd_data),
		.rd_valid_i (rd_valid),
		.fill_i     (fill),
		.fill_data_i(fill_data),
		.m_data_o   (m_data_o),
		.m_rdy_o    (m_rdy_o),
		.look_addr_o(look_addr),
		.wr_en_o    (wr_en),
		.wr_addr_o  (wr_addr),
		.wr_data_o  (wr_data),
		.wr_sel_o   (wr_sel),
		.wr_fill_o  (wr_fill),
		.push_o     (push),
		.miss_rqst_o(miss_rqst),
		.miss_addr_o(miss_addr)
	);

	dcache_store #(
		.ARCH_W   (ARCH_W),
		.SET_COUNT(SET_COUNT)
	) store0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.crst_i     (crst_i),
		.look_addr_i(look_addr),
		.wr_en_i    (wr_en),
		.wr_addr_i  (wr_addr),
		.wr_data_i  (wr_data),
		.wr_sel_i   (wr_sel),
		.wr_fill_i  (wr_fill),
		.rd_tag_o   (rd_tag),
		.rd_data_o  (rd_data),
		.rd_valid_o (rd_valid),
		.sweeping_o (sweeping)
	);

	dcache_wbuf #(
		.ARCH_W   (ARCH_W),
		.BUF_DEPTH(BUF_DEPTH)
	) wbuf0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.push_i     (push),
		.push_addr_i(m_addr_i),
		.push_data_i(m_data_i),
		.push_sel_i (m_sel_i),
		.pop_i      (pop),
		.head_addr_o(head_addr),
		.head_data_o(head_data),
		.head_sel_o (head_sel),
		.empty_o    (buf_empty),
		.full_o     (buf_full)
	);

	dcache_slave_ctrl #(
		.ARCH_W(ARCH_W)
	) sctrl0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.head_addr_i(head_addr),
		.head_data_i(head_data),
		.head_sel_i (head_sel),
		.empty_i    (buf_empty),
		.miss_rqst_i(miss_rqst),
		.miss_addr_i(miss_addr),
		.s_data_i   (s_data_i),
		.s_rdy_i    (s_rdy_i),
		.pop_o      (pop),
		.fill_o     (fill),
		.fill_data_o(fill_data),
		.s_op_o     (s_op_o),
		.s_addr_o   (s_addr_o),
		.s_data_o   (s_data_o),
		.s_sel_o    (s_sel_o)
	);

endmodule

// ==== tb/tb_slave_mem.sv ====
`timescale 1ns/10ps

module tb_slave_mem import dcache_pkg::*; #(
	parameter int ARCH_W = 32,
	parameter int ADDR_W = 30,
	parameter int MEM_WORDS = 1024,
	localparam int SEL_W = ARCH_W / BYTE_W,
	localparam int IDX_W = $clog2(MEM_WORDS)
) (
	input  logic              clk_i,
	input  pi1_op_e           op_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [ARCH_W-1:0] data_i,
	input  logic [SEL_W-1:0]  sel_i,
	input  logic              rdy_i,
	output logic [ARCH_W-1:0] data_o,
	output int                rd_count_o,
	output int                wr_count_o
);

	logic [ARCH_W-1:0] mem [MEM_WORDS];
	logic [ARCH_W-1:0] rd_q = '0;
	logic [ARCH_W-1:0] merged;
	logic [IDX_W-1:0]  idx;
	int                rd_count = 0;
	int                wr_count = 0;
	integer            seed;

	// The memory is word addressed and only the low address bits select a word.
	assign idx = addr_i[IDX_W-1:0];

	initial begin
		seed = 32'h8792_d16f;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] <= $random(seed);
		end
	end

	// Only the selected bytes of a write replace the stored word.
	always_comb begin
		merged = mem[idx];
		for (int b = 0; b < SEL_W; b++) begin
			if (sel_i[b]) begin
				merged[b*BYTE_W +: BYTE_W] = data_i[b*BYTE_W +: BYTE_W];
			end
		end
	end

	// A read is taken at a ready edge and its word is held until the next read.
	always @(posedge clk_i) begin
		if (rdy_i && op_i == PI1_RDOP) begin
			rd_q <= mem[idx];
			rd_count <= rd_count + 1;
		end else if (rdy_i && op_i == PI1_WROP) begin
			mem[idx] <= merged;
			wr_count <= wr_count + 1;
		end
	end

	assign data_o = rd_q;
	assign rd_count_o = rd_count;
	assign wr_count_o = wr_count;

endmodule

// ==== tb/tb_pi1_dcache.sv ====
`timescale 1ns/10ps

module tb_pi1_dcache import dcache_pkg::*; ();

	localparam int ARCH_W = 32;
	localparam int SET_COUNT = 16;
	localparam int BUF_DEPTH = 4;
	localparam int SEL_W = ARCH_W / BYTE_W;
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W);
	localparam int MEM_WORDS = 1024;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int WAIT_LIMIT = 200;

	logic              clk = 1'b0;
	logic              rst;
	logic              crst;
	logic              cenable;
	pi1_op_e           m_op;
	logic [ADDR_W-1:0] m_addr;
	logic [ARCH_W-1:0] m_data_w;
	logic [SEL_W-1:0]  m_sel;
	logic [ARCH_W-1:0] m_data_r;
	logic              m_rdy;
	pi1_op_e           s_op;
	logic [ADDR_W-1:0] s_addr;
	logic [ARCH_W-1:0] s_data_w;
	logic [SEL_W-1:0]  s_sel;
	logic [ARCH_W-1:0] s_data_r;
	logic              s_rdy;
	int                rd_count;
	int                wr_count;

	always #5 clk = !clk;

	pi1_dcache #(
		.ARCH_W   (ARCH_W),
		.SET_COUNT(SET_COUNT),
		.BUF_DEPTH(BUF_DEPTH)
	) dut0 (
		.clk_i    (clk),
		.rst_i    (rst),
		.crst_i   (crst),
		.cenable_i(cenable),
		.m_op_i   (m_op),
		.m_addr_i (m_addr),
		.m_data_i (m_data_w),
		.m_sel_i  (m_sel),
		.m_data_o (m_data_r),
		.m_rdy_o  (m_rdy),
		.s_op_o   (s_op),
		.s_addr_o (s_addr),
		.s_data_o (s_data_w),
		.s_sel_o  (s_sel),
		.s_data_i (s_data_r),
		.s_rdy_i  (s_rdy)
	);

	tb_slave_mem #(
		.ARCH_W   (ARCH_W),
		.ADDR_W   (ADDR_W),
		.MEM_WORDS(MEM_WORDS)
	) mem0 (
		.clk_i     (clk),
		.op_i      (s_op),
		.addr_i    (s_addr),
		.data_i    (s_data_w),
		.sel_i     (s_sel),
		.rdy_i     (s_rdy),
		.data_o    (s_data_r),
		.rd_count_o(rd_count),
		.wr_count_o(wr_count)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_data(input string test, input logic [ARCH_W-1:0] exp,
		input logic [ARCH_W-1:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("Error in %s: expected %h, actual %h", test, exp, act));
		end
	endtask

	task automatic check_op(input string test, input pi1_op_e exp, input pi1_op_e act);
		if (act !== exp) begin
			stop_with_failure($sformatf("Error in %s: expected %s, actual %s",
				test, exp.name(), act.name()));
		end
	endtask

	task automatic check_count(input string test, input int exp, input int act);
		if (act != exp) begin
			stop_with_failure($sformatf("Error in %s: expected %0d, actual %0d", test, exp, act));
		end
	endtask

	function automatic logic [ARCH_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
		return mem0.mem[addr[MEM_IDX_W-1:0]];
	endfunction

	function automatic logic [ARCH_W-1:0] sel_mask(input logic [SEL_W-1:0] sel);
		logic [ARCH_W-1:0] mask;
		for (int b = 0; b < SEL_W; b++) begin
			mask[b*BYTE_W +: BYTE_W] = {BYTE_W{sel[b]}};
		end
		return mask;
	endfunction

	// Selected bytes come from the new word, all others keep the old ones.
	function automatic logic [ARCH_W-1:0] merge_bytes(input logic [ARCH_W-1:0] old_w,
		input logic [ARCH_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		return (new_w & sel_mask(sel)) | (old_w & ~sel_mask(sel));
	endfunction

	// Returns at the falling edge of the first cycle with master ready high.
	task automatic wait_ready(input string test);
		int n;
		n = 0;
		@(negedge clk);
		while (!m_rdy) begin
			n++;
			if (n > WAIT_LIMIT) begin
				stop_with_failure($sformatf("%s: master ready stayed low too long", test));
			end
			@(negedge clk);
		end
	endtask

	// Presents one request and returns just after the edge that accepts it.
	task automatic issue(input string test, input pi1_op_e op, input logic [ADDR_W-1:0] addr,
		input logic [ARCH_W-1:0] data, input logic [SEL_W-1:0] sel);
		m_op = op;
		m_addr = addr;
		m_data_w = data;
		m_sel = sel;
		wait_ready(test);
		@(posedge clk);
		#1;
		m_op = PI1_NOOP;
	endtask

	task automatic read_word(input string test, input logic [ADDR_W-1:0] addr,
		input logic [SEL_W-1:0] sel, output logic [ARCH_W-1:0] data);
		issue(test, PI1_RDOP, addr, '0, sel);
		wait_ready(test);
		data = m_data_r;
		@(posedge clk);
		#1;
	endtask

	task automatic wait_writes(input string test, input int target);
		int n;
		n = 0;
		while (wr_count < target) begin
			n++;
			if (n > WAIT_LIMIT) begin
				stop_with_failure($sformatf("%s: buffered writes never reached the slave", test));
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic after_reset_test();
		int n;
		n = 0;
		@(negedge clk);
		while (!m_rdy) begin
			check_op("after_reset slave op", PI1_NOOP, s_op);
			n++;
			if (n > SET_COUNT + 4) begin
				stop_with_failure("master ready did not rise after the valid-bit sweep");
			end
			@(negedge clk);
		end
		if (n == 0) begin
			stop_with_failure("master ready was high during the valid-bit sweep");
		end
		check_op("after_reset slave op", PI1_NOOP, s_op);
		@(posedge clk);
		#1;
	endtask

	task automatic write_read_test();
		logic [ARCH_W-1:0] got;
		int reads;
		int writes;
		reads = rd_count;
		writes = wr_count;
		issue("write_read", PI1_WROP, 30'h010, 32'hcafe_0a51, '1);
		read_word("write_read", 30'h010, '1, got);
		check_data("write_read data", 32'hcafe_0a51, got);
		check_count("write_read slave reads", reads, rd_count);
		wait_writes("write_read", writes + 1);
		check_data("write_read memory", 32'hcafe_0a51, mem_word(30'h010));
	endtask

	task automatic read_miss_test();
		logic [ARCH_W-1:0] got;
		int reads;
		reads = rd_count;
		read_word("read_miss", 30'h025, '1, got);
		check_data("read_miss first data", mem_word(30'h025), got);
		check_count("read_miss first slave reads", reads + 1, rd_count);
		read_word("read_miss", 30'h025, '1, got);
		check_data("read_miss second data", mem_word(30'h025), got);
		check_count("read_miss second slave reads", reads + 1, rd_count);
	endtask

	task automatic partial_write_test();
		logic [ARCH_W-1:0] got;
		logic [ARCH_W-1:0] orig;
		int reads;
		orig = mem_word(30'h037);
		reads = rd_count;
		issue("partial_write", PI1_WROP, 30'h037, 32'h1234_abcd, 4'b0011);
		read_word("partial_write", 30'h037, 4'b0011, got);
		check_data("partial_write low bytes", 32'h1234_abcd & sel_mask(4'b0011),
			got & sel_mask(4'b0011));
		check_count("partial_write hit slave reads", reads, rd_count);
		read_word("partial_write", 30'h037, '1, got);
		check_data("partial_write merged word", merge_bytes(orig, 32'h1234_abcd, 4'b0011), got);
		check_count("partial_write miss slave reads", reads + 1, rd_count);
	endtask

	// The first and last writes share an address, so the last one must win.
	task automatic backpressure_test();
		logic [ADDR_W-1:0] addr [BUF_DEPTH];
		logic [ARCH_W-1:0] data [BUF_DEPTH];
		int writes;
		int last;
		for (int i = 0; i < BUF_DEPTH; i++) begin
			addr[i] = 30'h040 + ADDR_W'(i % 3);
			data[i] = {8'h5b, 8'(i), 16'h3c3c} ^ 32'(i * 7);
		end
		writes = wr_count;
		s_rdy = 1'b0;
		for (int i = 0; i < BUF_DEPTH; i++) begin
			issue("backpressure", PI1_WROP, addr[i], data[i], '1);
		end
		@(negedge clk);
		if (m_rdy) begin
			stop_with_failure("master ready stayed high with a full write buffer");
		end
		check_count("backpressure held writes", writes, wr_count);
		@(posedge clk);
		#1;
		s_rdy = 1'b1;
		wait_writes("backpressure", writes + BUF_DEPTH);
		for (int i = 0; i < BUF_DEPTH; i++) begin
			last = i;
			for (int j = i + 1; j < BUF_DEPTH; j++) begin
				if (addr[j] == addr[i]) begin
					last = j;
				end
			end
			check_data("backpressure memory", data[last], mem_word(addr[i]));
		end
	endtask

	task automatic bypass_flush_test();
		logic [ARCH_W-1:0] got;
		int reads;
		reads = rd_count;
		cenable = 1'b0;
		for (int i = 0; i < 3; i++) begin
			read_word("bypass", 30'h074, '1, got);
			check_data("bypass data", mem_word(30'h074), got);
			check_count("bypass slave reads", reads + i + 1, rd_count);
		end
		cenable = 1'b1;
		read_word("flush", 30'h025, '1, got);
		check_data("flush cached data", mem_word(30'h025), got);
		check_count("flush cached slave reads", reads + 3, rd_count);
		crst = 1'b1;
		@(posedge clk);
		#1;
		crst = 1'b0;
		read_word("flush", 30'h025, '1, got);
		check_data("flush refetched data", mem_word(30'h025), got);
		check_count("flush refetched slave reads", reads + 4, rd_count);
	endtask

	initial begin
		rst = 1'b1;
		crst = 1'b0;
		cenable = 1'b1;
		m_op = PI1_NOOP;
		m_addr = '0;
		m_data_w = '0;
		m_sel = '0;
		s_rdy = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		after_reset_test();
		write_read_test();
		read_miss_test();
		partial_write_test();
		backpressure_test();
		bypass_flush_test();
		$display("No errors");
		$finish;
	end

endmodule

// ==== pi1_dcache.f ====
src/dcache_pkg.sv
src/dcache_decode.sv
src/dcache_store.sv
src/dcache_wbuf.sv
src/dcache_slave_ctrl.sv
src/pi1_dcache.sv
tb/tb_slave_mem.sv
tb/tb_pi1_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_pi1_dcache \
	-f pi1_dcache.f \
	-o sim_pi1_dcache \
	&& ./obj_dir/sim_pi1_dcache \
	|| { echo "simulation did not pass"; exit 1; }
